// ==== common/fetch_pkg.sv ====
package fetch_pkg;

    // Address and predictor geometry
    localparam int XLEN            = 32;
    localparam int GHR_WIDTH       = 8;
    localparam int PHT_DEPTH       = 2 ** GHR_WIDTH;
    localparam int BTB_INDEX_WIDTH = 6;
    localparam int BTB_DEPTH       = 2 ** BTB_INDEX_WIDTH;
    localparam int BTB_TAG_WIDTH   = XLEN - BTB_INDEX_WIDTH - 2;

    // Reset values
    localparam logic [XLEN-1:0] RESET_PC  = '0;
    localparam logic [1:0]      CTR_RESET = 2'b01;

    // PC as seen by the BTB
    typedef struct packed {
        logic [BTB_TAG_WIDTH-1:0]   tag;
        logic [BTB_INDEX_WIDTH-1:0] index;
        logic [1:0]                 offset;
    } btb_view_t;

    // PC as seen by the PHT, before hashing with history
    typedef struct packed {
        logic [XLEN-GHR_WIDTH-3:0] unused;
        logic [GHR_WIDTH-1:0]      index;
        logic [1:0]                offset;
    } pht_view_t;

    typedef union packed {
        btb_view_t btb;
        pht_view_t pht;
    } fetch_pc_u;

    // Prediction for the PC currently in fetch
    typedef struct packed {
        logic                 btb_hit;
        logic                 pred_taken;
        logic [XLEN-1:0]      target;
        logic [GHR_WIDTH-1:0] ghr;
    } predict_t;

    // One resolved control-flow instruction coming back from execute
    typedef struct packed {
        logic                 valid;
        logic                 is_cond;
        logic                 is_jal;
        logic                 is_jalr;
        logic                 taken;
        logic                 pred_taken;
        logic                 btb_hit;
        logic [XLEN-1:0]      pc;
        logic [XLEN-1:0]      target;
        logic [GHR_WIDTH-1:0] ghr;
    } resolve_t;

endpackage

// ==== logic/fetch_ctrl.sv ====
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           fetch_stall_i,
    input  fetch_pkg::resolve_t            resolve_i,
    input  logic                           btb_hit_i,
    input  logic [fetch_pkg::XLEN-1:0]      btb_target_i,
    input  logic                           ctr_taken_i,
    input  logic [fetch_pkg::GHR_WIDTH-1:0] ghr_i,
    output fetch_pkg::fetch_pc_u           pc_o,
    output fetch_pkg::predict_t            predict_o,
    output logic                           train_o,
    output logic                           alloc_o,
    output logic                           flush_o
);

    import fetch_pkg::*;

    fetch_pc_u       pc_q;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] res_plus4;
    logic [XLEN-1:0] recover_pc;
    logic [XLEN-1:0] predict_pc;
    logic [XLEN-1:0] next_pc;
    logic            pred_taken;
    logic            trainable;
    logic            mispredict;

    // Prediction only when the BTB knows a target for this PC
    assign pred_taken = btb_hit_i & ctr_taken_i;

    always_comb begin
        predict_o            = '0;
        predict_o.btb_hit    = btb_hit_i;
        predict_o.pred_taken = pred_taken;
        predict_o.target     = btb_target_i;
        predict_o.ghr        = ghr_i;
    end

    // Conditional branches and jal train both tables
    assign trainable = resolve_i.valid & (resolve_i.is_cond | resolve_i.is_jal);
    assign train_o   = trainable;
    assign alloc_o   = trainable & resolve_i.taken;

    // jalr has no usable prediction, so it always redirects
    assign mispredict = (trainable & (resolve_i.pred_taken ^ resolve_i.taken))
                      | (resolve_i.valid & resolve_i.is_jalr);
    assign flush_o    = mispredict;

    assign pc_plus4  = pc_q + XLEN'(4);
    assign res_plus4 = resolve_i.pc + XLEN'(4);

    assign recover_pc = resolve_i.taken ? resolve_i.target : res_plus4;
    assign predict_pc = pred_taken ? btb_target_i : pc_plus4;

    // Recovery wins over stall
    always_comb begin
        if (mispredict) begin
            next_pc = recover_pc;
        end else if (fetch_stall_i) begin
            next_pc = pc_q;
        end else begin
            next_pc = predict_pc;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= next_pc;
        end
    end

    assign pc_o = pc_q;

endmodule

// ==== predictor/gshare_pht.sv ====
`timescale 1ns/1ps

module gshare_pht (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  fetch_pkg::fetch_pc_u            rd_pc_i,
    input  logic                            train_i,
    input  fetch_pkg::resolve_t             resolve_i,
    output logic                            ctr_taken_o,
    output logic [fetch_pkg::GHR_WIDTH-1:0] ghr_o
);

    import fetch_pkg::*;

    logic [GHR_WIDTH-1:0] ghr_q;
    logic [1:0]           pht_q [PHT_DEPTH];

    fetch_pc_u            wr_pc;
    logic [GHR_WIDTH-1:0] rd_idx;
    logic [GHR_WIDTH-1:0] wr_idx;
    logic [1:0]           ctr_cur;
    logic [1:0]           ctr_next;

    // Read side hashes with the live history
    assign rd_idx      = rd_pc_i.pht.index ^ ghr_q;
    assign ctr_taken_o = pht_q[rd_idx][1];
    assign ghr_o       = ghr_q;

    // Write side uses the snapshot the branch carried down the pipe
    assign wr_pc  = resolve_i.pc;
    assign wr_idx = wr_pc.pht.index ^ resolve_i.ghr;

    assign ctr_cur = pht_q[wr_idx];

    // Two-bit saturating counter
    always_comb begin
        ctr_next = ctr_cur;
        if (resolve_i.taken) begin
            if (ctr_cur != 2'b11) begin
                ctr_next = ctr_cur + 2'b01;
            end
        end else begin
            if (ctr_cur != 2'b00) begin
                ctr_next = ctr_cur - 2'b01;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < PHT_DEPTH; i++) begin
                pht_q[i] <= CTR_RESET;
            end
        end else if (train_i) begin
            pht_q[wr_idx] <= ctr_next;
        end
    end

    // History only moves on resolved branches, not on fetch
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ghr_q <= '0;
        end else if (train_i) begin
            ghr_q <= {ghr_q[GHR_WIDTH-2:0], resolve_i.taken};
        end
    end

endmodule

// ==== predictor/branch_target_buffer.sv ====
`timescale 1ns/1ps

module branch_target_buffer (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  fetch_pkg::fetch_pc_u       rd_pc_i,
    input  logic                       alloc_i,
    input  fetch_pkg::resolve_t        resolve_i,
    output logic                       hit_o,
    output logic [fetch_pkg::XLEN-1:0] target_o
);

    import fetch_pkg::*;

    logic                     valid_q  [BTB_DEPTH];
    logic [BTB_TAG_WIDTH-1:0] tag_q    [BTB_DEPTH];
    logic [XLEN-1:0]          target_q [BTB_DEPTH];

    fetch_pc_u                wr_pc;
    logic [BTB_INDEX_WIDTH-1:0] rd_idx;
    logic [BTB_INDEX_WIDTH-1:0] wr_idx;

    assign rd_idx = rd_pc_i.btb.index;
    assign wr_pc  = resolve_i.pc;
    assign wr_idx = wr_pc.btb.index;

    // Direct mapped lookup
    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_pc_i.btb.tag);
    assign target_o = target_q[rd_idx];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < BTB_DEPTH; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (alloc_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Tag and target overwrite whatever entry sat at this index
    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            tag_q[wr_idx]    <= wr_pc.btb.tag;
            target_q[wr_idx] <= resolve_i.target;
        end
    end

endmodule

// ==== logic/fetch_unit_top.sv ====
`timescale 1ns/1ps

module fetch_unit_top (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       fetch_stall_i,
    input  fetch_pkg::resolve_t        resolve_i,
    output logic [fetch_pkg::XLEN-1:0] fetch_pc_o,
    output fetch_pkg::predict_t        predict_o,
    output logic                       flush_o
);

    import fetch_pkg::*;

    fetch_pc_u            fetch_pc;
    logic                 btb_hit;
    logic [XLEN-1:0]      btb_target;
    logic                 ctr_taken;
    logic [GHR_WIDTH-1:0] ghr;
    logic                 train;
    logic                 alloc;

    assign fetch_pc_o = fetch_pc;

    fetch_ctrl fetch_ctrl_i (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .fetch_stall_i (fetch_stall_i),
        .resolve_i     (resolve_i),
        .btb_hit_i     (btb_hit),
        .btb_target_i  (btb_target),
        .ctr_taken_i   (ctr_taken),
        .ghr_i         (ghr),
        .pc_o          (fetch_pc),
        .predict_o     (predict_o),
        .train_o       (train),
        .alloc_o       (alloc),
        .flush_o       (flush_o)
    );

    // Direction from gshare
    gshare_pht gshare_pht_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .rd_pc_i     (fetch_pc),
        .train_i     (train),
        .resolve_i   (resolve_i),
        .ctr_taken_o (ctr_taken),
        .ghr_o       (ghr)
    );

    // Target from the BTB
    branch_target_buffer branch_target_buffer_i (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .rd_pc_i   (fetch_pc),
        .alloc_i   (alloc),
        .resolve_i (resolve_i),
        .hit_o     (btb_hit),
        .target_o  (btb_target)
    );

endmodule

// ==== bench/fetch_unit_checker.sv ====
`timescale 1ns/1ps

module fetch_unit_checker (
    input logic                       clk_i,
    input logic                       rst_ni,
    input logic                       fetch_stall_i,
    input fetch_pkg::resolve_t        resolve_i,
    input logic [fetch_pkg::XLEN-1:0] fetch_pc_i,
    input logic                       flush_i
);

    // Flush only comes from a resolved instruction
    flush_needs_resolve: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        flush_i |-> resolve_i.valid
    ) else $error("flush_o high without a valid resolve packet");

    // Stall freezes fetch unless recovery takes over
    stall_holds_pc: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (fetch_stall_i && !flush_i) |=> $stable(fetch_pc_i)
    ) else $error("fetch_pc_o moved during a stall without flush");

    // All targets in this system are word aligned
    pc_word_aligned: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        fetch_pc_i[1:0] == 2'b00
    ) else $error("fetch_pc_o lost word alignment");

endmodule

bind fetch_unit_top fetch_unit_checker fetch_unit_checker_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fetch_stall_i (fetch_stall_i),
    .resolve_i     (resolve_i),
    .fetch_pc_i    (fetch_pc_o),
    .flush_i       (flush_o)
);

// ==== bench/fetch_unit_tb.sv ====
`timescale 1ns/1ps

module fetch_unit_tb;

    import fetch_pkg::*;

    localparam int unsigned     SEED         = 32'h23e4;
    localparam int              RESET_CYCLES = 10;
    localparam int              TRAIN_LIMIT  = 20;
    localparam int              RANDOM_OPS   = 400;
    localparam int              KIND_COND    = 0;
    localparam int              KIND_JAL     = 1;
    localparam int              KIND_JALR    = 2;
    localparam logic [XLEN-1:0] ADDR_MASK    = 32'h0000_03fc;
    localparam logic [XLEN-1:0] BR_PC        = 32'h0000_0100;
    localparam logic [XLEN-1:0] BR_TARGET    = 32'h0000_0200;
    localparam logic [XLEN-1:0] JUMP_PC      = 32'h0000_0080;

    logic            clk;
    logic            rst_n;
    logic            fetch_stall;
    resolve_t        resolve;
    logic [XLEN-1:0] fetch_pc;
    predict_t        predict;
    logic            flush;

    // Reference state of the tables and the PC
    logic [1:0]               pht_model [PHT_DEPTH];
    logic [GHR_WIDTH-1:0]     ghr_model;
    logic                     btb_valid_model [BTB_DEPTH];
    logic [BTB_TAG_WIDTH-1:0] btb_tag_model [BTB_DEPTH];
    logic [XLEN-1:0]          btb_target_model [BTB_DEPTH];
    logic [XLEN-1:0]          pc_model;

    fetch_unit_top fetch_unit_top_i (
        .clk_i         (clk),
        .rst_ni        (rst_n),
        .fetch_stall_i (fetch_stall),
        .resolve_i     (resolve),
        .fetch_pc_o    (fetch_pc),
        .predict_o     (predict),
        .flush_o       (flush)
    );

    always #5 clk = ~clk;

    task automatic stop_with_failure();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        assert (actual === expected) else begin
            $display("ERR t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic reset_model();
        for (int i = 0; i < PHT_DEPTH; i++) begin
            pht_model[i] = 2'b01;
        end
        for (int i = 0; i < BTB_DEPTH; i++) begin
            btb_valid_model[i]  = 1'b0;
            btb_tag_model[i]    = '0;
            btb_target_model[i] = '0;
        end
        ghr_model = '0;
        pc_model  = '0;
    endtask

    // Expected prediction for a fetch address from the model tables
    function automatic predict_t expected_predict(input logic [XLEN-1:0] pc);
        predict_t                   p;
        logic [BTB_INDEX_WIDTH-1:0] bi;
        logic [GHR_WIDTH-1:0]       pi;
        bi = pc[BTB_INDEX_WIDTH+1:2];
        pi = pc[GHR_WIDTH+1:2] ^ ghr_model;
        p            = '0;
        p.btb_hit    = btb_valid_model[bi] && (btb_tag_model[bi] == pc[XLEN-1:BTB_INDEX_WIDTH+2]);
        p.pred_taken = p.btb_hit && pht_model[pi][1];
        p.target     = btb_target_model[bi];
        p.ghr        = ghr_model;
        return p;
    endfunction

    function automatic logic expected_flush(input resolve_t r);
        logic trainable;
        trainable = r.valid && (r.is_cond || r.is_jal);
        return (trainable && (r.pred_taken != r.taken)) || (r.valid && r.is_jalr);
    endfunction

    function automatic logic [XLEN-1:0] expected_next_pc(input resolve_t r, input logic stall,
                                                          input predict_t p);
        if (expected_flush(r)) begin
            return r.taken ? r.target : r.pc + XLEN'(4);
        end
        if (stall) begin
            return pc_model;
        end
        return p.pred_taken ? p.target : pc_model + XLEN'(4);
    endfunction

    // Advance the model by one clock edge
    task automatic update_model(input resolve_t r, input logic stall, input predict_t p);
        logic [GHR_WIDTH-1:0]       wi;
        logic [BTB_INDEX_WIDTH-1:0] bi;
        pc_model = expected_next_pc(r, stall, p);
        if (r.valid && (r.is_cond || r.is_jal)) begin
            wi = r.pc[GHR_WIDTH+1:2] ^ r.ghr;
            if (r.taken && pht_model[wi] != 2'd3) begin
                pht_model[wi] = pht_model[wi] + 2'd1;
            end else if (!r.taken && pht_model[wi] != 2'd0) begin
                pht_model[wi] = pht_model[wi] - 2'd1;
            end
            ghr_model = {ghr_model[GHR_WIDTH-2:0], r.taken};
            if (r.taken) begin
                bi                   = r.pc[BTB_INDEX_WIDTH+1:2];
                btb_valid_model[bi]  = 1'b1;
                btb_tag_model[bi]    = r.pc[XLEN-1:BTB_INDEX_WIDTH+2];
                btb_target_model[bi] = r.target;
            end
        end
    endtask

    always @(posedge clk) begin
        predict_t exp_p;
        logic     exp_flush;
        if (!rst_n) begin
            reset_model();
        end else begin
            exp_p     = expected_predict(pc_model);
            exp_flush = expected_flush(resolve);
            check_value("fetch_pc_o", pc_model, fetch_pc);
            check_value("flush_o", XLEN'(exp_flush), XLEN'(flush));
            check_value("predict_o.btb_hit", XLEN'(exp_p.btb_hit), XLEN'(predict.btb_hit));
            check_value("predict_o.pred_taken", XLEN'(exp_p.pred_taken),
                        XLEN'(predict.pred_taken));
            check_value("predict_o.ghr", XLEN'(exp_p.ghr), XLEN'(predict.ghr));
            // Target only means something on a hit
            if (exp_p.btb_hit) begin
                check_value("predict_o.target", exp_p.target, predict.target);
            end
            update_model(resolve, fetch_stall, exp_p);
        end
    end

    function automatic resolve_t make_resolve(input int kind, input logic [XLEN-1:0] pc,
                                              input logic taken, input logic [XLEN-1:0] target,
                                              input logic pred_taken,
                                              input logic [GHR_WIDTH-1:0] ghr);
        resolve_t r;
        r            = '0;
        r.valid      = 1'b1;
        r.is_cond    = (kind == KIND_COND);
        r.is_jal     = (kind == KIND_JAL);
        r.is_jalr    = (kind == KIND_JALR);
        r.taken      = (kind == KIND_COND) ? taken : 1'b1;
        r.pred_taken = pred_taken;
        r.btb_hit    = pred_taken;
        r.pc         = pc;
        r.target     = target;
        r.ghr        = ghr;
        return r;
    endfunction

    task automatic drive_cycle(input logic stall, input resolve_t r);
        @(negedge clk);
        fetch_stall = stall;
        resolve     = r;
    endtask

    initial begin
        logic        trained;
        int          tries;
        int          kind;
        resolve_t    r;
        clk         = 1'b0;
        rst_n       = 1'b0;
        fetch_stall = 1'b0;
        resolve     = '0;
        void'($urandom(SEED));
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Sequential fetch, then a stall
        repeat (8) drive_cycle(1'b0, '0);
        repeat (4) drive_cycle(1'b1, '0);
        drive_cycle(1'b0, '0);

        // Train one branch until fetch predicts it taken
        trained = 1'b0;
        tries   = 0;
        while (!trained && tries < TRAIN_LIMIT) begin
            drive_cycle(1'b0, make_resolve(KIND_COND, BR_PC, 1'b1, BR_TARGET, 1'b0, ghr_model));
            drive_cycle(1'b0, make_resolve(KIND_JALR, JUMP_PC, 1'b1, BR_PC, 1'b0, ghr_model));
            drive_cycle(1'b0, '0);
            trained = predict.pred_taken;
            tries++;
        end
        if (!trained) begin
            $display("Branch at %h was never predicted taken after %0d trainings", BR_PC, tries);
            stop_with_failure();
        end
        drive_cycle(1'b0, '0);

        // Mispredict recovery in both directions, under stall
        drive_cycle(1'b1, make_resolve(KIND_COND, BR_PC, 1'b0, BR_TARGET, 1'b1, ghr_model));
        drive_cycle(1'b1, make_resolve(KIND_COND, 32'h0000_0140, 1'b1, 32'h0000_0300, 1'b0,
                                       ghr_model));
        drive_cycle(1'b0, '0);

        // Indirect jumps always redirect
        drive_cycle(1'b0, make_resolve(KIND_JALR, 32'h0000_0040, 1'b1, 32'h0000_0180, 1'b1,
                                       ghr_model));
        drive_cycle(1'b1, make_resolve(KIND_JALR, 32'h0000_0044, 1'b1, 32'h0000_0020, 1'b0,
                                       ghr_model));
        drive_cycle(1'b0, '0);

        // Random resolve stream mixed with stalls
        for (int n = 0; n < RANDOM_OPS; n++) begin
            kind = int'($urandom % 3);
            r = make_resolve(kind, $urandom & ADDR_MASK, ($urandom % 2) == 1,
                             $urandom & ADDR_MASK, ($urandom % 2) == 1, GHR_WIDTH'($urandom));
            r.valid   = ($urandom % 3) != 0;
            r.btb_hit = ($urandom % 2) == 1;
            drive_cycle(($urandom % 4) == 0, r);
        end
        drive_cycle(1'b0, '0);
        drive_cycle(1'b0, '0);
        @(negedge clk);
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== sim.f ====
common/fetch_pkg.sv
logic/fetch_ctrl.sv
predictor/gshare_pht.sv
predictor/branch_target_buffer.sv
logic/fetch_unit_top.sv
bench/fetch_unit_checker.sv
bench/fetch_unit_tb.sv

// ==== Makefile ====
# Verilator build and run for the fetch unit testbench

VERILATOR ?= verilator
TOP       ?= fetch_unit_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: sim clean

# A failed check ends in $$fatal, which gives a nonzero exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
